// File: hw/dcache.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache
   import dcache_pkg::*;
(
   input  logic                  CLK,
   input  logic                  nRST,
   // datapath side
   input  logic                  halt,
   input  logic                  dmemren,
   input  logic                  dmemwen,
   input  logic [`WORD_W-1:0]    dmemaddr,
   input  logic [`WORD_W-1:0]    dmemstore,
   output logic [`WORD_W-1:0]    dmemload,
   output logic                  dhit,
   output logic                  flushed,
   // memory side
   output logic                  dren,
   output logic                  dwen,
   output logic [`WORD_W-1:0]    daddr,
   output logic [`WORD_W-1:0]    dstore,
   input  logic [`WORD_W-1:0]    dload,
   input  logic                  dwait
);

   dcache_addr_u                       req_addr;
   logic [`IDX_W-1:0]                  idx, fl_idx;
   logic [`TAG_W-1:0]                  rd_tag0, rd_tag1, fl_tag0, fl_tag1;
   logic                               rd_valid0, rd_valid1, rd_dirty0, rd_dirty1;
   logic [2**`BLK_W-1:0][`WORD_W-1:0]  rd_data0, rd_data1, fl_data0, fl_data1;
   logic                               lru, fl_dirty0, fl_dirty1;
   logic                               hit, hit_way, victim_way, victim_dirty;
   logic [`WORD_W-1:0]                 hit_word, victim_word0, victim_word1;
   logic [`TAG_W-1:0]                  victim_tag, tag;
   logic [`BLK_W-1:0]                  blkoff, wr_word;
   logic                               wr_en, wr_way, wr_dirty, clr_dirty;
   logic                               touch, touch_way;
   logic [`WORD_W-1:0]                 wr_data;
   logic [`TAG_W-1:0]                  wr_tag;

   assign req_addr = dmemaddr;

   dcache_ways ways (.*);

   dcache_lookup lookup (
      .dmemaddr(req_addr),
      .*
   );

   dcache_ctrl ctrl (.*);

endmodule

// File: hw/dcache_ctrl.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_ctrl
   import dcache_pkg::*;
(
   input  logic                                     CLK,
   input  logic                                     nRST,
   // datapath request
   input  logic                                     halt,
   input  logic                                     dmemren,
   input  logic                                     dmemwen,
   input  logic [`WORD_W-1:0]                       dmemaddr,
   input  logic [`WORD_W-1:0]                       dmemstore,
   // lookup results
   input  logic                                     hit,
   input  logic                                     hit_way,
   input  logic                                     victim_way,
   input  logic                                     victim_dirty,
   input  logic [`BLK_W-1:0]                        blkoff,
   input  logic [`TAG_W-1:0]                        tag,
   input  logic [`IDX_W-1:0]                        idx,
   input  logic [`WORD_W-1:0]                       hit_word,
   input  logic [`WORD_W-1:0]                       victim_word0,
   input  logic [`WORD_W-1:0]                       victim_word1,
   input  logic [`TAG_W-1:0]                        victim_tag,
   // flush walk view
   input  logic                                     fl_dirty0,
   input  logic                                     fl_dirty1,
   input  logic [`TAG_W-1:0]                        fl_tag0,
   input  logic [`TAG_W-1:0]                        fl_tag1,
   input  logic [2**`BLK_W-1:0][`WORD_W-1:0]        fl_data0,
   input  logic [2**`BLK_W-1:0][`WORD_W-1:0]        fl_data1,
   // memory side
   input  logic [`WORD_W-1:0]                       dload,
   input  logic                                     dwait,
   // storage updates
   output logic                                     wr_en,
   output logic                                     wr_way,
   output logic [`BLK_W-1:0]                        wr_word,
   output logic [`WORD_W-1:0]                       wr_data,
   output logic [`TAG_W-1:0]                        wr_tag,
   output logic                                     wr_dirty,
   output logic                                     clr_dirty,
   output logic                                     touch,
   output logic                                     touch_way,
   output logic [`IDX_W-1:0]                        fl_idx,
   // results
   output logic [`WORD_W-1:0]                       dmemload,
   output logic                                     dhit,
   output logic                                     flushed,
   output logic                                     dren,
   output logic                                     dwen,
   output logic [`WORD_W-1:0]                       daddr,
   output logic [`WORD_W-1:0]                       dstore
);

   localparam logic [2:0] idle        = 3'd0;
   localparam logic [2:0] wb_first    = 3'd1;
   localparam logic [2:0] wb_second   = 3'd2;
   localparam logic [2:0] fill_first  = 3'd3;
   localparam logic [2:0] fill_second = 3'd4;
   localparam logic [2:0] flush_way0  = 3'd5;
   localparam logic [2:0] flush_way1  = 3'd6;
   localparam logic [2:0] done        = 3'd7;

   logic [2:0]               state;
   logic [2:0]               next_state;
   logic [`FLUSH_IDX_W-1:0]  fl_cnt;
   logic [`FLUSH_IDX_W-1:0]  next_cnt;
   logic [`BLK_W-1:0]        fl_off;
   logic [`BLK_W-1:0]        next_off;
   logic                     fl_way;     // way being flushed
   dcache_addr_u             mem_addr;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state  <= idle;
         fl_cnt <= '0;
         fl_off <= '0;
      end
      else
      begin
         state  <= next_state;
         fl_cnt <= next_cnt;
         fl_off <= next_off;
      end
   end

   assign fl_idx   = fl_cnt[`IDX_W-1:0];
   assign fl_way   = (state == flush_way1);
   assign dmemload = hit_word;   // after the first fill the requested word hits
   assign daddr    = mem_addr.raw;

   always_comb
   begin
      next_state = state;
      next_cnt   = fl_cnt;
      next_off   = fl_off;
      dhit       = 1'b0;
      flushed    = 1'b0;
      dren       = 1'b0;
      dwen       = 1'b0;
      dstore     = '0;
      mem_addr   = dmemaddr;
      wr_en      = 1'b0;
      wr_way     = victim_way;
      wr_word    = blkoff;
      wr_data    = dload;
      wr_tag     = tag;
      wr_dirty   = dmemwen;
      clr_dirty  = 1'b0;
      touch      = 1'b0;
      touch_way  = victim_way;

      case (state)
         idle:
         begin
            if (halt)
               next_state = flush_way0;
            else if (dmemren || dmemwen)
            begin
               if (hit)
               begin
                  dhit      = 1'b1;
                  touch     = 1'b1;
                  touch_way = hit_way;
                  if (dmemwen)
                  begin
                     wr_en    = 1'b1;
                     wr_way   = hit_way;
                     wr_data  = dmemstore;
                     wr_dirty = 1'b1;
                  end
               end
               else if (victim_dirty)
                  next_state = wb_first;
               else
                  next_state = fill_first;
            end
         end
         wb_first:
         begin
            dwen              = 1'b1;
            mem_addr.f.tag    = victim_tag;
            mem_addr.f.idx    = idx;
            mem_addr.f.bytoff = '0;
            dstore            = blkoff[0] ? victim_word1 : victim_word0;
            if (!dwait)
               next_state = wb_second;
         end
         wb_second:
         begin
            dwen              = 1'b1;
            mem_addr.f.tag    = victim_tag;
            mem_addr.f.idx    = idx;
            mem_addr.f.blkoff = ~blkoff;   // partner word
            mem_addr.f.bytoff = '0;
            dstore            = blkoff[0] ? victim_word0 : victim_word1;
            if (!dwait)
               next_state = fill_first;
         end
         fill_first:
         begin
            dren              = 1'b1;
            mem_addr.f.bytoff = '0;
            if (!dwait)
            begin
               wr_en      = 1'b1;
               wr_data    = dmemwen ? dmemstore : dload;   // store merges here
               next_state = fill_second;
            end
         end
         fill_second:
         begin
            dren              = 1'b1;
            mem_addr.f.blkoff = ~blkoff;
            mem_addr.f.bytoff = '0;
            if (!dwait)
            begin
               wr_en      = 1'b1;
               wr_word    = ~blkoff;
               dhit       = 1'b1;
               touch      = 1'b1;
               next_state = idle;
            end
         end
         flush_way0, flush_way1:
         begin
            if (fl_cnt[`IDX_W])
            begin
               // end of this way
               next_cnt   = '0;
               next_state = fl_way ? done : flush_way1;
            end
            else if (fl_way ? fl_dirty1 : fl_dirty0)
            begin
               dwen              = 1'b1;
               mem_addr.f.tag    = fl_way ? fl_tag1 : fl_tag0;
               mem_addr.f.idx    = fl_idx;
               mem_addr.f.blkoff = fl_off;
               mem_addr.f.bytoff = '0;
               dstore            = fl_way ? fl_data1[fl_off] : fl_data0[fl_off];
               if (!dwait)
               begin
                  if (fl_off[0])
                  begin
                     next_off  = '0;
                     next_cnt  = fl_cnt + 1'b1;
                     clr_dirty = 1'b1;   // block fully written back
                     wr_way    = fl_way;
                  end
                  else
                     next_off = fl_off + 1'b1;
               end
            end
            else
               next_cnt = fl_cnt + 1'b1;   // clean entry skipped
         end
         done:
            flushed = 1'b1;
         default:
            next_state = idle;
      endcase
   end

endmodule

// File: hw/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// word and address width
`define WORD_W 32

// eight sets of two ways
`define SETS 8
`define IDX_W 3

// two words per block
`define BLK_W 1
`define BYT_W 2

// whatever is left of the address above idx
`define TAG_W 26

// one extra bit so the walk can count to SETS
`define FLUSH_IDX_W (`IDX_W + 1)

`endif

// File: hw/dcache_lookup.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_lookup
   import dcache_pkg::*;
(
   input  dcache_addr_u                             dmemaddr,
   // set contents
   input  logic [`TAG_W-1:0]                        rd_tag0,
   input  logic [`TAG_W-1:0]                        rd_tag1,
   input  logic                                     rd_valid0,
   input  logic                                     rd_valid1,
   input  logic                                     rd_dirty0,
   input  logic                                     rd_dirty1,
   input  logic [2**`BLK_W-1:0][`WORD_W-1:0]        rd_data0,
   input  logic [2**`BLK_W-1:0][`WORD_W-1:0]        rd_data1,
   input  logic                                     lru,
   // hit facts
   output logic                                     hit,
   output logic                                     hit_way,
   output logic [`WORD_W-1:0]                       hit_word,
   // victim facts
   output logic                                     victim_way,
   output logic                                     victim_dirty,
   output logic [`TAG_W-1:0]                        victim_tag,
   output logic [`WORD_W-1:0]                       victim_word0,
   output logic [`WORD_W-1:0]                       victim_word1,
   // request fields
   output logic [`IDX_W-1:0]                        idx,
   output logic [`BLK_W-1:0]                        blkoff,
   output logic [`TAG_W-1:0]                        tag
);

   logic hit0;
   logic hit1;

   assign tag    = dmemaddr.f.tag;
   assign idx    = dmemaddr.f.idx;
   assign blkoff = dmemaddr.f.blkoff;

   assign hit0 = rd_valid0 && (rd_tag0 == tag);
   assign hit1 = rd_valid1 && (rd_tag1 == tag);

   assign hit     = hit0 || hit1;
   assign hit_way = hit1;   // both can not match one tag
   assign hit_word = hit_way ? rd_data1[blkoff] : rd_data0[blkoff];

   // LRU bit points straight at the victim
   assign victim_way   = lru;
   assign victim_dirty = victim_way ? (rd_valid1 && rd_dirty1) : (rd_valid0 && rd_dirty0);
   assign victim_tag   = victim_way ? rd_tag1 : rd_tag0;
   assign victim_word0 = victim_way ? rd_data1[0] : rd_data0[0];
   assign victim_word1 = victim_way ? rd_data1[1] : rd_data0[1];

endmodule

// File: hw/dcache_pkg.sv
`include "dcache_defs.svh"

package dcache_pkg;

   // an address word can be read raw or as cache fields
   typedef union packed
   {
      logic [`WORD_W-1:0] raw;
      struct packed
      {
         logic [`TAG_W-1:0] tag;
         logic [`IDX_W-1:0] idx;
         logic [`BLK_W-1:0] blkoff;
         logic [`BYT_W-1:0] bytoff;   // always zero on the memory side
      } f;
   } dcache_addr_u;

endpackage

// File: hw/dcache_ways.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_ways
   import dcache_pkg::*;
(
   input  logic                                     CLK,
   input  logic                                     nRST,
   // request set
   input  logic [`IDX_W-1:0]                        idx,
   output logic [`TAG_W-1:0]                        rd_tag0,
   output logic [`TAG_W-1:0]                        rd_tag1,
   output logic                                     rd_valid0,
   output logic                                     rd_valid1,
   output logic                                     rd_dirty0,
   output logic                                     rd_dirty1,
   output logic [2**`BLK_W-1:0][`WORD_W-1:0]        rd_data0,
   output logic [2**`BLK_W-1:0][`WORD_W-1:0]        rd_data1,
   output logic                                     lru,
   // flush walk set
   input  logic [`IDX_W-1:0]                        fl_idx,
   output logic                                     fl_dirty0,
   output logic                                     fl_dirty1,
   output logic [`TAG_W-1:0]                        fl_tag0,
   output logic [`TAG_W-1:0]                        fl_tag1,
   output logic [2**`BLK_W-1:0][`WORD_W-1:0]        fl_data0,
   output logic [2**`BLK_W-1:0][`WORD_W-1:0]        fl_data1,
   // updates from the controller
   input  logic                                     wr_en,
   input  logic                                     wr_way,
   input  logic [`BLK_W-1:0]                        wr_word,
   input  logic [`WORD_W-1:0]                       wr_data,
   input  logic [`TAG_W-1:0]                        wr_tag,
   input  logic                                     wr_dirty,
   input  logic                                     clr_dirty,
   input  logic                                     touch,
   input  logic                                     touch_way
);

   // storage indexed by way first
   logic [`TAG_W-1:0]                  tags [2][`SETS];
   logic [2**`BLK_W-1:0][`WORD_W-1:0]  data [2][`SETS];
   logic [1:0][`SETS-1:0]              valid;
   logic [1:0][`SETS-1:0]              dirty;
   logic [`SETS-1:0]                   lru_bits;   // names the next victim of each set

   // tag and data words
   always_ff @(posedge CLK)
   begin
      if (wr_en)
      begin
         tags[wr_way][idx]          <= wr_tag;
         data[wr_way][idx][wr_word] <= wr_data;
      end
   end

   // state bits
   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         valid    <= '0;
         dirty    <= '0;
         lru_bits <= '0;
      end
      else
      begin
         if (wr_en)
         begin
            valid[wr_way][idx] <= 1'b1;
            dirty[wr_way][idx] <= wr_dirty;
         end
         if (clr_dirty)
            dirty[wr_way][fl_idx] <= 1'b0;   // flush entry written back
         if (touch)
            lru_bits[idx] <= ~touch_way;
      end
   end

   // request set view
   assign rd_tag0   = tags[0][idx];
   assign rd_tag1   = tags[1][idx];
   assign rd_valid0 = valid[0][idx];
   assign rd_valid1 = valid[1][idx];
   assign rd_dirty0 = dirty[0][idx];
   assign rd_dirty1 = dirty[1][idx];
   assign rd_data0  = data[0][idx];
   assign rd_data1  = data[1][idx];
   assign lru       = lru_bits[idx];

   // flush walk view
   assign fl_dirty0 = dirty[0][fl_idx];
   assign fl_dirty1 = dirty[1][fl_idx];
   assign fl_tag0   = tags[0][fl_idx];
   assign fl_tag1   = tags[1][fl_idx];
   assign fl_data0  = data[0][fl_idx];
   assign fl_data1  = data[1][fl_idx];

endmodule

// File: list.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_ways.sv
hw/dcache_lookup.sv
hw/dcache_ctrl.sv
hw/dcache.sv
verif/tb_ram.sv
verif/dcache_tb.sv

// File: run.sh
#!/bin/bash
# compile and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f list.f \
   --top-module dcache_tb --Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

output=$(./obj_dir/dcache_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
   exit 0
fi
exit 1

// File: verif/dcache_tb.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_tb
   import dcache_pkg::*;
();

   localparam int                 MAX_CYCLES = 3000;   // all tests need under 1000
   localparam logic [`WORD_W-1:0] SEED       = 32'he6e4;

   logic               CLK, nRST, halt, dmemren, dmemwen, dhit, flushed;
   logic               dren, dwen, dwait;
   logic [`WORD_W-1:0] dmemaddr, dmemstore, dmemload, daddr, dstore, dload;
   logic [`WORD_W-1:0] rng;
   logic [`WORD_W-1:0] d1, d2, d3, d4, d5;   // store data
   int                 errors, tests, failed, base_err, cycles;

   dcache UUT (.*);
   tb_ram #(.SEED(SEED)) ram (.*);

   always #20 CLK = ~CLK;

   always @(posedge CLK)
   begin
      cycles++;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Timeout after %0d cycles, the cache stopped answering", cycles);
         $display("Verification failed");
         $finish;
      end
   end

   function automatic logic [`WORD_W-1:0] lcg(input logic [`WORD_W-1:0] x);
      return x * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [`WORD_W-1:0] rand_word();
      rng = lcg(rng);
      return rng;
   endfunction

   // memory word that was never written
   function automatic logic [`WORD_W-1:0] mem_word(input logic [`WORD_W-1:0] addr);
      return addr * 32'd1664525 + SEED;
   endfunction

   function automatic logic [`WORD_W-1:0] addr_of(input int tag, input int idx, input int off);
      dcache_addr_u a;
      a          = '0;
      a.f.tag    = tag[`TAG_W-1:0];
      a.f.idx    = idx[`IDX_W-1:0];
      a.f.blkoff = off[`BLK_W-1:0];
      return a.raw;
   endfunction

   task automatic check(input string name, input logic [`WORD_W-1:0] got, want);
      if (got !== want)
      begin
         $display("Error: %s is %h, expected %h", name, got, want);
         errors++;
      end
   endtask

   // hold one request until dhit, then drop it
   task automatic request(input logic wr, input logic [`WORD_W-1:0] addr, data, want_load,
                          input logic want_mem);
      logic used_mem;
      used_mem  = 1'b0;
      dmemren   = !wr;
      dmemwen   = wr;
      dmemaddr  = addr;
      dmemstore = data;
      do
      begin
         @(negedge CLK);
         used_mem = used_mem || dren || dwen;
      end while (!dhit);
      if (!wr)
         check("dmemload", dmemload, want_load);
      check("dren|dwen", 32'(used_mem), 32'(want_mem));
      @(posedge CLK);
      #2;
      dmemren = 1'b0;
      dmemwen = 1'b0;
   endtask

   task automatic expect_write(input int n, input logic [`WORD_W-1:0] addr, data);
      check("daddr", ram.log_addr[n], addr);
      check("dstore", ram.log_data[n], data);
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors == base_err)
         $display("%s: ok", name);
      else
      begin
         failed++;
         $display("%s: %0d errors", name, errors - base_err);
      end
      base_err = errors;
   endtask

   task automatic test_read_miss();
      check("dhit,dren,dwen,flushed", 32'({dhit, dren, dwen, flushed}), 32'd0);
      request(1'b0, addr_of(1, 1, 1), '0, mem_word(addr_of(1, 1, 1)), 1'b1);
      request(1'b0, addr_of(1, 1, 0), '0, mem_word(addr_of(1, 1, 0)), 1'b0);   // partner hits
      end_test("read miss and fill");
   endtask

   task automatic test_write_hit();
      d1 = rand_word();
      request(1'b1, addr_of(1, 1, 0), d1, '0, 1'b0);
      request(1'b0, addr_of(1, 1, 0), '0, d1, 1'b0);
      check("write count", 32'(ram.log_addr.size()), 32'd0);
      end_test("write hit");
   endtask

   task automatic test_dirty_evict();
      int base;
      base = ram.log_addr.size();
      d2   = rand_word();
      d3   = rand_word();
      request(1'b1, addr_of(1, 1, 1), d2, '0, 1'b0);
      request(1'b0, addr_of(2, 1, 0), '0, mem_word(addr_of(2, 1, 0)), 1'b1);   // other way
      request(1'b1, addr_of(3, 1, 0), d3, '0, 1'b1);   // tag 1 is the dirty victim
      check("write count", 32'(ram.log_addr.size() - base), 32'd2);
      expect_write(base, addr_of(1, 1, 0), d1);
      expect_write(base + 1, addr_of(1, 1, 1), d2);
      request(1'b0, addr_of(1, 1, 0), '0, d1, 1'b1);   // back from memory
      request(1'b0, addr_of(1, 1, 1), '0, d2, 1'b0);
      check("write count", 32'(ram.log_addr.size() - base), 32'd2);
      end_test("dirty eviction");
   endtask

   task automatic test_lru();
      request(1'b0, addr_of(4, 2, 0), '0, mem_word(addr_of(4, 2, 0)), 1'b1);   // A
      request(1'b0, addr_of(5, 2, 0), '0, mem_word(addr_of(5, 2, 0)), 1'b1);   // B
      request(1'b0, addr_of(4, 2, 1), '0, mem_word(addr_of(4, 2, 1)), 1'b0);
      request(1'b0, addr_of(6, 2, 0), '0, mem_word(addr_of(6, 2, 0)), 1'b1);   // C evicts B
      request(1'b0, addr_of(4, 2, 0), '0, mem_word(addr_of(4, 2, 0)), 1'b0);
      request(1'b0, addr_of(5, 2, 1), '0, mem_word(addr_of(5, 2, 1)), 1'b1);
      end_test("LRU choice");
   endtask

   task automatic test_halt_flush();
      int base;
      base = ram.log_addr.size();
      d4   = rand_word();
      d5   = rand_word();
      request(1'b1, addr_of(7, 3, 1), d4, '0, 1'b1);   // set 3 way 0
      request(1'b1, addr_of(5, 2, 0), d5, '0, 1'b0);   // set 2 way 1
      halt = 1'b1;
      while (!flushed)
         @(negedge CLK);
      // dirty blocks in walk order with way 0 first
      check("write count", 32'(ram.log_addr.size() - base), 32'd6);
      expect_write(base, addr_of(3, 1, 0), d3);
      expect_write(base + 1, addr_of(3, 1, 1), mem_word(addr_of(3, 1, 1)));
      expect_write(base + 2, addr_of(7, 3, 0), mem_word(addr_of(7, 3, 0)));
      expect_write(base + 3, addr_of(7, 3, 1), d4);
      expect_write(base + 4, addr_of(5, 2, 0), d5);
      expect_write(base + 5, addr_of(5, 2, 1), mem_word(addr_of(5, 2, 1)));
      repeat (4)
      begin
         @(negedge CLK);
         check("flushed", 32'(flushed), 32'd1);
      end
      check("write count", 32'(ram.log_addr.size() - base), 32'd6);
      end_test("halt flush");
   endtask

   initial
   begin
      CLK       = 1'b0;
      nRST      = 1'b0;
      halt      = 1'b0;
      dmemren   = 1'b0;
      dmemwen   = 1'b0;
      dmemaddr  = '0;
      dmemstore = '0;
      rng       = SEED;
      errors    = 0;
      tests     = 0;
      failed    = 0;
      base_err  = 0;
      cycles    = 0;
      repeat (5) @(posedge CLK);
      #2;
      nRST = 1'b1;
      test_read_miss();
      test_write_hit();
      test_dirty_evict();
      test_lru();
      test_halt_flush();
      $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// File: verif/tb_ram.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module tb_ram #(
   parameter logic [`WORD_W-1:0] SEED = 32'he6e4
) (
   input  logic                 CLK,
   input  logic                 nRST,
   input  logic                 dren,
   input  logic                 dwen,
   input  logic [`WORD_W-1:0]   daddr,
   input  logic [`WORD_W-1:0]   dstore,
   output logic [`WORD_W-1:0]   dload,
   output logic                 dwait
);

   logic [`WORD_W-1:0] mem [logic [`WORD_W-1:0]];   // written words only
   logic [1:0]         wait_cnt;
   logic [`WORD_W-1:0] log_addr [$];   // every completed write in order
   logic [`WORD_W-1:0] log_data [$];

   // contents of a word never written
   function automatic logic [`WORD_W-1:0] fill_word(input logic [`WORD_W-1:0] addr);
      return addr * 32'd1664525 + SEED;
   endfunction

   assign dwait = (wait_cnt != 2'd2);   // low on the third cycle of a request

   always @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         wait_cnt <= '0;
         dload    <= '0;
      end
      else
      begin
         // address is stable for the whole request
         dload <= mem.exists(daddr) ? mem[daddr] : fill_word(daddr);
         if (!(dren || dwen) || !dwait)
            wait_cnt <= '0;
         else
            wait_cnt <= wait_cnt + 2'd1;
         if (dwen && !dwait)
         begin
            mem[daddr] = dstore;
            log_addr.push_back(daddr);
            log_data.push_back(dstore);
         end
      end
   end

endmodule
